// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing -sv
SIM_FLAGS  = --binary --timing --assert -sv
TOP        = tb_aud_top
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = ERRORS FOUND
PASS_MSG   = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/aud_ctrl.sv ====
`timescale 1ns/1ps

module aud_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_rec,
    input  logic                       i_play,
    input  logic                       i_pause,
    input  logic                       i_stop,
    input  logic                       i_rec_done,
    input  logic                       i_play_done,
    input  logic [aud_pkg::ADDR_W-1:0] i_rec_count,
    output logic                       o_rec_start,
    output logic                       o_play_start,
    output logic                       o_rec_pause,
    output logic                       o_rec_stop,
    output logic                       o_play_pause,
    output logic                       o_play_stop,
    output logic                       o_busy,
    output logic [aud_pkg::ADDR_W-1:0] o_len
);
    import aud_pkg::*;

    aud_mode_e         mode_r, mode_w;
    logic [ADDR_W-1:0] len_r, len_w;

    // record wins if both keys come together.
    assign o_rec_start  = (mode_r == MODE_IDLE) && i_rec;
    assign o_play_start = (mode_r == MODE_IDLE) && i_play && !i_rec;

    // pause and stop only reach the active block.
    assign o_rec_pause  = (mode_r == MODE_REC) && i_pause;
    assign o_rec_stop   = (mode_r == MODE_REC) && i_stop;
    assign o_play_pause = (mode_r == MODE_PLAY) && i_pause;
    assign o_play_stop  = (mode_r == MODE_PLAY) && i_stop;

    assign o_busy = mode_r != MODE_IDLE;
    assign o_len  = len_r;

    always_comb begin
        mode_w = mode_r;
        len_w  = len_r;
        case (mode_r)
            MODE_IDLE: begin
                if (i_rec) begin
                    mode_w = MODE_REC;
                end else if (i_play) begin
                    mode_w = MODE_PLAY;
                end
            end
            MODE_REC: begin
                if (i_rec_done) begin
                    len_w  = i_rec_count;
                    mode_w = MODE_IDLE;
                end
            end
            MODE_PLAY: begin
                if (i_play_done) begin
                    mode_w = MODE_IDLE;
                end
            end
            default: begin
                mode_w = MODE_IDLE;
            end
        endcase
    end

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            mode_r <= MODE_IDLE;
            len_r  <= '0;
        end else begin
            mode_r <= mode_w;
            len_r  <= len_w;
        end
    end

endmodule

// ==== rtl/aud_mem_if.sv ====
`timescale 1ns/1ps

interface aud_mem_if;
    import aud_pkg::*;

    logic                we;
    logic [ADDR_W-1:0]   waddr;
    logic [SAMPLE_W-1:0] wdata;
    logic [ADDR_W-1:0]   raddr;
    logic [SAMPLE_W-1:0] rdata;

    modport rec (
        output we,
        output waddr,
        output wdata
    );

    modport play (
        output raddr,
        input  rdata
    );

    modport ram (
        input  we,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface

// ==== rtl/aud_pkg.sv ====
package aud_pkg;

    // sample word width.
    localparam int SAMPLE_W = 16;

    // sample address width, as wide as the external store it replaces.
    localparam int ADDR_W = 20;

    // on-chip sample store.
    localparam int MEM_WORDS = 256;

    // index bits actually decoded by the store.
    localparam int MEM_AW = $clog2(MEM_WORDS);

    // serial bit counter, counts 0 to SAMPLE_W.
    localparam int CNT_W = $clog2(SAMPLE_W + 1);

    // top-level operating mode.
    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_REC,
        MODE_PLAY
    } aud_mode_e;

endpackage

// ==== rtl/aud_player.sv ====
`timescale 1ns/1ps

module aud_player (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_lrc,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic                       i_stop,
    input  logic [aud_pkg::ADDR_W-1:0] i_len,
    aud_mem_if.play                    mem,
    output logic                       o_dac_data,
    output logic                       o_done
);
    import aud_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE,
        P_WAIT,
        P_LOAD,
        P_SHIFT,
        P_PAUSE,
        P_FINISH
    } play_state_e;

    play_state_e         state_r, state_w;
    logic [ADDR_W-1:0]   addr_r, addr_w;
    logic [CNT_W-1:0]    bit_cnt_r, bit_cnt_w;
    logic [SAMPLE_W-1:0] shift_r, shift_w;
    logic                dac_r, dac_w;

    assign mem.raddr  = addr_r;
    assign o_dac_data = dac_r;
    assign o_done     = state_r == P_FINISH;

    always_comb begin
        state_w   = state_r;
        addr_w    = addr_r;
        bit_cnt_w = bit_cnt_r;
        shift_w   = shift_r;
        // line is silent unless a word is going out.
        dac_w     = 1'b0;
        case (state_r)
            P_IDLE: begin
                if (i_start) begin
                    addr_w = '0;
                    if (i_len == '0) begin
                        state_w = P_FINISH;
                    end else begin
                        state_w = P_WAIT;
                    end
                end
            end
            P_WAIT: begin
                if (i_stop) begin
                    state_w = P_FINISH;
                end else if (i_pause) begin
                    state_w = P_PAUSE;
                end else if (i_lrc) begin
                    state_w = P_LOAD;
                end
            end
            P_LOAD: begin
                if (i_stop) begin
                    state_w = P_FINISH;
                end else if (i_pause) begin
                    state_w = P_PAUSE;
                end else if (!i_lrc) begin
                    // rdata settled during the right half.
                    shift_w   = {mem.rdata[SAMPLE_W-2:0], 1'b0};
                    dac_w     = mem.rdata[SAMPLE_W-1];
                    bit_cnt_w = CNT_W'(1);
                    state_w   = P_SHIFT;
                end
            end
            P_SHIFT: begin
                if (i_stop) begin
                    state_w = P_FINISH;
                end else if (i_pause) begin
                    state_w = P_PAUSE;
                end else if (bit_cnt_r == CNT_W'(SAMPLE_W)) begin
                    addr_w = addr_r + 1'b1;
                    if (addr_r + 1'b1 == i_len) begin
                        state_w = P_FINISH;
                    end else begin
                        state_w = P_WAIT;
                    end
                end else begin
                    dac_w     = shift_r[SAMPLE_W-1];
                    shift_w   = {shift_r[SAMPLE_W-2:0], 1'b0};
                    bit_cnt_w = bit_cnt_r + 1'b1;
                end
            end
            P_PAUSE: begin
                if (i_stop) begin
                    state_w = P_FINISH;
                end else if (i_pause) begin
                    state_w = P_WAIT;
                end
            end
            P_FINISH: begin
                state_w = P_IDLE;
            end
            default: begin
                state_w = P_IDLE;
            end
        endcase
    end

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= P_IDLE;
            addr_r    <= '0;
            bit_cnt_r <= '0;
            dac_r     <= 1'b0;
        end else begin
            state_r   <= state_w;
            addr_r    <= addr_w;
            bit_cnt_r <= bit_cnt_w;
            dac_r     <= dac_w;
        end
    end

    always_ff @(negedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

// ==== rtl/aud_recorder.sv ====
`timescale 1ns/1ps

module aud_recorder (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_lrc,
    input  logic                       i_adc_data,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic                       i_stop,
    aud_mem_if.rec                     mem,
    output logic                       o_done,
    output logic [aud_pkg::ADDR_W-1:0] o_count
);
    import aud_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_REC,
        S_PAUSE,
        S_FINISH
    } rec_state_e;

    rec_state_e          state_r, state_w;
    logic [ADDR_W-1:0]   count_r, count_w;
    logic [SAMPLE_W-1:0] data_r, data_w;
    logic [CNT_W-1:0]    bit_cnt_r, bit_cnt_w;
    logic                lrc_q;
    logic                frame_start;
    logic                word_full;

    // left half begins at the first low after a high.
    assign frame_start = lrc_q && !i_lrc;
    assign word_full   = bit_cnt_r == CNT_W'(SAMPLE_W);

    assign mem.we    = (state_r == S_REC) && word_full;
    assign mem.waddr = count_r;
    assign mem.wdata = data_r;
    assign o_done    = state_r == S_FINISH;
    assign o_count   = count_r;

    always_comb begin
        state_w   = state_r;
        count_w   = count_r;
        data_w    = data_r;
        bit_cnt_w = bit_cnt_r;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    count_w = '0;
                    state_w = S_WAIT;
                end
            end
            S_WAIT: begin
                if (i_stop) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (frame_start) begin
                    // this edge is the one-bit delay slot.
                    bit_cnt_w = '0;
                    state_w   = S_REC;
                end
            end
            S_REC: begin
                if (word_full) begin
                    // word goes to memory on this edge.
                    count_w = count_r + 1'b1;
                    if (i_stop || count_r == ADDR_W'(MEM_WORDS - 1)) begin
                        state_w = S_FINISH;
                    end else if (i_pause) begin
                        state_w = S_PAUSE;
                    end else begin
                        state_w = S_WAIT;
                    end
                end else if (i_stop) begin
                    // partial word is dropped.
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else begin
                    data_w    = {data_r[SAMPLE_W-2:0], i_adc_data};
                    bit_cnt_w = bit_cnt_r + 1'b1;
                end
            end
            S_PAUSE: begin
                if (i_stop) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_WAIT;
                end
            end
            S_FINISH: begin
                state_w = S_IDLE;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(negedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= S_IDLE;
            count_r   <= '0;
            bit_cnt_r <= '0;
            lrc_q     <= 1'b0;
        end else begin
            state_r   <= state_w;
            count_r   <= count_w;
            bit_cnt_r <= bit_cnt_w;
            lrc_q     <= i_lrc;
        end
    end

    always_ff @(negedge i_clk) begin
        data_r <= data_w;
    end

    // each word is written on the edge after its 16th bit.
    a_we_timing: assert property (@(negedge i_clk) disable iff (i_rst_n)
        mem.we |-> $past(frame_start, SAMPLE_W + 1));

    a_count_limit: assert property (@(negedge i_clk) disable iff (i_rst_n)
        count_r <= ADDR_W'(MEM_WORDS));

endmodule

// ==== rtl/aud_sample_ram.sv ====
`timescale 1ns/1ps

module aud_sample_ram (
    input  logic   i_clk,
    aud_mem_if.ram mem
);
    import aud_pkg::*;

    logic [SAMPLE_W-1:0] ram_r [MEM_WORDS];
    logic [SAMPLE_W-1:0] rdata_r;
    logic [MEM_AW-1:0]   widx;
    logic [MEM_AW-1:0]   ridx;

    // upper address bits are not decoded.
    assign widx      = mem.waddr[MEM_AW-1:0];
    assign ridx      = mem.raddr[MEM_AW-1:0];
    assign mem.rdata = rdata_r;

    always_ff @(negedge i_clk) begin
        if (mem.we) begin
            ram_r[widx] <= mem.wdata;
        end
    end

    // read data one edge after the address.
    always_ff @(negedge i_clk) begin
        rdata_r <= ram_r[ridx];
    end

    // the recorder must stop before the store wraps.
    a_waddr_range: assert property (@(negedge i_clk)
        mem.we |-> mem.waddr < ADDR_W'(MEM_WORDS));

endmodule

// ==== rtl/aud_top.sv ====
`timescale 1ns/1ps

module aud_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_lrc,
    input  logic                       i_adc_data,
    input  logic                       i_rec,
    input  logic                       i_play,
    input  logic                       i_pause,
    input  logic                       i_stop,
    output logic                       o_dac_data,
    output logic                       o_busy,
    output logic [aud_pkg::ADDR_W-1:0] o_rec_len
);
    import aud_pkg::*;

    logic              rec_start;
    logic              play_start;
    logic              rec_pause;
    logic              rec_stop;
    logic              play_pause;
    logic              play_stop;
    logic              rec_done;
    logic              play_done;
    logic [ADDR_W-1:0] rec_count;

    aud_mem_if mem_bus ();

    aud_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rec        (i_rec),
        .i_play       (i_play),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_rec_done   (rec_done),
        .i_play_done  (play_done),
        .i_rec_count  (rec_count),
        .o_rec_start  (rec_start),
        .o_play_start (play_start),
        .o_rec_pause  (rec_pause),
        .o_rec_stop   (rec_stop),
        .o_play_pause (play_pause),
        .o_play_stop  (play_stop),
        .o_busy       (o_busy),
        .o_len        (o_rec_len)
    );

    aud_recorder u_recorder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_adc_data (i_adc_data),
        .i_start    (rec_start),
        .i_pause    (rec_pause),
        .i_stop     (rec_stop),
        .mem        (mem_bus.rec),
        .o_done     (rec_done),
        .o_count    (rec_count)
    );

    // playback length is the last recorded length.
    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (play_start),
        .i_pause    (play_pause),
        .i_stop     (play_stop),
        .i_len      (o_rec_len),
        .mem        (mem_bus.play),
        .o_dac_data (o_dac_data),
        .o_done     (play_done)
    );

    aud_sample_ram u_ram (
        .i_clk (i_clk),
        .mem   (mem_bus.ram)
    );

endmodule

// ==== verif/tb_aud_top.sv ====
`timescale 1ns/1ps

module tb_aud_top;
    import aud_pkg::*;

    localparam int FRAME_CYC = 40;

    logic                i_clk;
    logic                i_rst_n;
    logic                i_lrc;
    logic                i_adc_data;
    logic                i_rec;
    logic                i_play;
    logic                i_pause;
    logic                i_stop;
    logic                o_dac_data;
    logic                o_busy;
    logic [ADDR_W-1:0]   o_rec_len;

    // pos is the bit time within the frame.
    int                  pos = FRAME_CYC - 1;
    int                  frame_no = -1;
    int                  np;
    integer              seed = 12784;
    integer              rnd;
    logic [SAMPLE_W-1:0] smp = '0;
    logic [SAMPLE_W-1:0] frame_q[$];

    // expected playback words indexed by frame number minus play_first.
    logic [SAMPLE_W-1:0] exp_words[$];
    int                  play_first = 0;
    int                  play_cnt = 0;
    bit                  checking = 1'b0;
    int                  idx;
    logic                cur_valid = 1'b0;
    logic [SAMPLE_W-1:0] cur_word = '0;
    logic                exp_bit;

    int                  errors = 0;
    int                  checks = 0;
    int                  dac_errors = 0;
    int                  dac_checks = 0;
    int                  rec_first;
    int                  rec_last;
    int                  pause_first;
    int                  pause_last;

    aud_top u_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_adc_data (i_adc_data),
        .i_rec      (i_rec),
        .i_play     (i_play),
        .i_pause    (i_pause),
        .i_stop     (i_stop),
        .o_dac_data (o_dac_data),
        .o_busy     (o_busy),
        .o_rec_len  (o_rec_len)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #20;
            i_clk = ~i_clk;
        end
    end

    // bit times 1 to 16 carry the word MSB first and all others are zero.
    function automatic logic serial_bit(input logic [SAMPLE_W-1:0] word, input int p);
        logic [SAMPLE_W-1:0] shifted;
        shifted = '0;
        if (p >= 1 && p <= SAMPLE_W) begin
            shifted = word >> (SAMPLE_W - p);
        end
        return shifted[0];
    endfunction

    // a frame is kept if it lies in the record window and outside the pause window.
    function automatic bit stored_frame(input int f, input int first, input int last,
                                        input int p_first, input int p_last);
        return f >= first && f <= last && !(f >= p_first && f <= p_last);
    endfunction

    task automatic build_expected(input int first, input int last,
                                  input int p_first, input int p_last);
        exp_words.delete();
        for (int f = first; f <= last; f++) begin
            if (stored_frame(f, first, last, p_first, p_last)) begin
                exp_words.push_back(frame_q[f]);
            end
        end
    endtask

    // codec model with 20 low and 20 high bit times per frame.
    initial begin
        i_lrc      = 1'b1;
        i_adc_data = 1'b0;
        forever begin
            @(posedge i_clk);
            np = (pos + 1) % FRAME_CYC;
            if (np == 0) begin
                rnd = $random(seed);
                smp = rnd[SAMPLE_W-1:0];
                frame_q.push_back(smp);
                frame_no <= frame_no + 1;
            end
            pos        <= np;
            i_lrc      <= np >= FRAME_CYC / 2;
            i_adc_data <= serial_bit(smp, np);
        end
    end

    // dac line compare on each falling edge.
    always @(negedge i_clk) begin
        if (checking) begin
            if (pos == 0) begin
                idx       = frame_no - play_first;
                cur_valid = idx >= 0 && idx < play_cnt;
                if (cur_valid) begin
                    cur_word = exp_words[idx];
                end
            end
            exp_bit = cur_valid ? serial_bit(cur_word, pos) : 1'b0;
            dac_checks++;
            if (o_dac_data !== exp_bit) begin
                dac_errors++;
                $display("error at %0t: o_dac_data is %b, expected %b in frame %0d bit time %0d",
                         $time, o_dac_data, exp_bit, frame_no, pos);
            end
        end
    end

    task automatic finish_run;
        $display("checks %0d, errors %0d, serial checks %0d, serial errors %0d",
                 checks, errors, dac_checks, dac_errors);
        if (errors == 0 && dac_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    // returns on the rising edge that starts bit time p.
    task automatic wait_cycle(input int p);
        int n;
        n = 0;
        @(posedge i_clk);
        while (pos != (p + FRAME_CYC - 1) % FRAME_CYC && n < 2 * FRAME_CYC) begin
            @(posedge i_clk);
            n++;
        end
        if (n >= 2 * FRAME_CYC) begin
            fail_timeout("a frame position");
        end
    endtask

    task automatic wait_frames(input int count);
        for (int i = 0; i < count; i++) begin
            wait_cycle(25);
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(posedge i_clk);
        while (o_busy !== 1'b0 && n < limit) begin
            @(posedge i_clk);
            n++;
        end
        if (o_busy !== 1'b0) begin
            fail_timeout("o_busy to drop");
        end
    endtask

    // keys are {rec, play, pause, stop} and are pressed in the right half.
    task automatic press_key(input logic [3:0] keys);
        wait_cycle(25);
        i_rec   <= keys[3];
        i_play  <= keys[2];
        i_pause <= keys[1];
        i_stop  <= keys[0];
        @(posedge i_clk);
        i_rec   <= 1'b0;
        i_play  <= 1'b0;
        i_pause <= 1'b0;
        i_stop  <= 1'b0;
    endtask

    task automatic check_rec_len(input int exp_len);
        checks++;
        if (int'(o_rec_len) != exp_len) begin
            errors++;
            $display("error at %0t: o_rec_len is %0d, expected %0d", $time, o_rec_len, exp_len);
        end
    endtask

    task automatic check_end_frame(input int exp_frame);
        checks++;
        if (frame_no != exp_frame) begin
            errors++;
            $display("error at %0t: o_busy dropped in frame %0d, expected frame %0d",
                     $time, frame_no, exp_frame);
        end
    endtask

    task automatic play_and_check;
        press_key(4'b0100);
        play_first = frame_no + 1;
        play_cnt   = exp_words.size();
        wait_idle((play_cnt + 2) * FRAME_CYC);
        check_end_frame(play_first + play_cnt - 1);
    endtask

    initial begin
        i_rst_n = 1'b1;
        i_rec   = 1'b0;
        i_play  = 1'b0;
        i_pause = 1'b0;
        i_stop  = 1'b0;
        @(posedge i_clk);
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b0;
        @(posedge i_clk);
        checking = 1'b1;

        checks++;
        if (o_dac_data !== 1'b0 || o_busy !== 1'b0 || o_rec_len !== '0) begin
            errors++;
            $display("error at %0t: after reset dac %b busy %b len %0d, expected all zero",
                     $time, o_dac_data, o_busy, o_rec_len);
        end

        // record 10 frames and stop in a right half.
        press_key(4'b1000);
        rec_first = frame_no + 1;
        checks++;
        if (o_busy !== 1'b1) begin
            errors++;
            $display("error at %0t: o_busy is %b after the record key, expected 1",
                     $time, o_busy);
        end
        wait_frames(9);
        press_key(4'b0001);
        rec_last = frame_no;
        wait_idle(2 * FRAME_CYC);
        build_expected(rec_first, rec_last, 1, 0);
        check_rec_len(exp_words.size());
        play_and_check();

        // pause in the middle skips three frames.
        press_key(4'b1000);
        rec_first = frame_no + 1;
        wait_frames(3);
        press_key(4'b0010);
        pause_first = frame_no + 1;
        wait_frames(2);
        press_key(4'b0010);
        pause_last = frame_no;
        wait_frames(3);
        press_key(4'b0001);
        rec_last = frame_no;
        wait_idle(2 * FRAME_CYC);
        build_expected(rec_first, rec_last, pause_first, pause_last);
        check_rec_len(exp_words.size());
        play_and_check();

        // without a stop key the memory limit ends the recording.
        press_key(4'b1000);
        rec_first = frame_no + 1;
        wait_idle((MEM_WORDS + 2) * FRAME_CYC);
        rec_last = rec_first + MEM_WORDS - 1;
        check_end_frame(rec_last);
        check_rec_len(MEM_WORDS);
        build_expected(rec_first, rec_last, 1, 0);

        // stop playback after four words.
        press_key(4'b0100);
        play_first = frame_no + 1;
        play_cnt   = exp_words.size();
        wait_frames(3);
        press_key(4'b0001);
        play_cnt = frame_no - play_first + 1;
        wait_idle(2 * FRAME_CYC);
        wait_frames(2);
        checks++;
        if (o_busy !== 1'b0) begin
            errors++;
            $display("error at %0t: o_busy is %b after stop, expected 0", $time, o_busy);
        end

        finish_run();
    end

endmodule

// ==== vlog.f ====
rtl/aud_pkg.sv
rtl/aud_mem_if.sv
rtl/aud_recorder.sv
rtl/aud_player.sv
rtl/aud_sample_ram.sv
rtl/aud_ctrl.sv
rtl/aud_top.sv
verif/tb_aud_top.sv
